/* tb.f */
+incdir+rtl
rtl/tcdm_bus_pkg.sv
rtl/split_state_pkg.sv
rtl/tcdm_fifo.sv
rtl/tcdm_chan_buffer.sv
rtl/tcdm_split.sv
rtl/tcdm_split_top.sv
verification/tb_mem_channels.sv
verification/tb_tcdm_split.sv

/* verification/tb_tcdm_split.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_split_config.svh"

// random wide traffic against a byte enable memory model and per channel slice checks
module tb_tcdm_split;

  import tcdm_bus_pkg::*;

  localparam int unsigned NB_CHAN    = `TCDM_NB_CHAN;
  localparam int unsigned AW         = `TCDM_AW;
  localparam int unsigned NDW        = `TCDM_NARROW_DW;
  localparam int unsigned NBW        = NDW / 8;
  localparam int unsigned WBW        = `TCDM_WIDE_DW / 8;
  localparam int unsigned N_WORDS    = 16;       // wide words in the test window
  localparam int unsigned N_RANDOM   = 140;      // random requests in each traffic phase
  localparam int unsigned MAX_CYCLES = 300 * 20; // up to 300 requests at 20 cycles each
  localparam int          SEED       = 51;
  localparam logic [NDW-1:0] DUMMY_WORD = 32'h600D_D00D;

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  logic        req_i;
  wide_req_t   wide_req_i;
  logic        gnt_o;
  logic        r_valid_o;
  wide_rsp_t   wide_rsp_o;
  logic        r_ready_i;
  logic        chan_req_o      [NB_CHAN];
  narrow_req_t chan_req_o_data [NB_CHAN];
  logic        chan_gnt_i      [NB_CHAN];
  logic        chan_r_valid_i  [NB_CHAN];
  narrow_rsp_t chan_rsp_i      [NB_CHAN];
  logic        chan_r_ready_o  [NB_CHAN];

  logic [`TCDM_WIDE_DW-1:0] model_mem [N_WORDS];
  wide_req_t   acc_q[$];            // every accepted wide request, in order
  wide_rsp_t   exp_rsp_q[$];        // expected wide responses, in order
  int unsigned nreq_cnt [NB_CHAN];  // narrow requests seen per channel
  int unsigned rsp_cnt;
  int unsigned cycle_cnt;
  int          seed;
  logic        heavy_stall;         // r_ready_i mostly low when set

  tcdm_split_top dut (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .clear_i         ( clear_i         ),
    .req_i           ( req_i           ),
    .wide_req_i      ( wide_req_i      ),
    .gnt_o           ( gnt_o           ),
    .r_valid_o       ( r_valid_o       ),
    .wide_rsp_o      ( wide_rsp_o      ),
    .r_ready_i       ( r_ready_i       ),
    .chan_req_o      ( chan_req_o      ),
    .chan_req_o_data ( chan_req_o_data ),
    .chan_gnt_i      ( chan_gnt_i      ),
    .chan_r_valid_i  ( chan_r_valid_i  ),
    .chan_rsp_i      ( chan_rsp_i      ),
    .chan_r_ready_o  ( chan_r_ready_o  )
  );

  tb_mem_channels #(
    .SEED       ( SEED       ),
    .DUMMY_WORD ( DUMMY_WORD )
  ) i_mem (
    .clk_i      ( clk_i           ),
    .rst_ni     ( rst_ni          ),
    .req_i      ( chan_req_o      ),
    .req_data_i ( chan_req_o_data ),
    .r_ready_i  ( chan_r_ready_o  ),
    .gnt_o      ( chan_gnt_i      ),
    .r_valid_o  ( chan_r_valid_i  ),
    .rsp_o      ( chan_rsp_i      )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_with(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_wide_rsp(input string name, input wide_rsp_t got, input wide_rsp_t exp);
    if (got !== exp) begin
      fail_with($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_narrow_req(input string name, input narrow_req_t got,
                                  input narrow_req_t exp);
    if (got !== exp) begin
      fail_with($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  // channel c owns the word at add + 4c and slice c of be and data
  function automatic narrow_req_t expected_slice(input wide_req_t w, input int c);
    narrow_req_t s;
    s.add  = w.add + AW'(c * NBW);
    s.wen  = w.wen;
    s.be   = w.be[c*NBW +: NBW];
    s.data = w.data[c*NDW +: NDW];
    return s;
  endfunction

  // model takes effect in acceptance order, which is also the memory order per channel
  task automatic accept_request(input wide_req_t rq);
    logic [3:0] idx;
    wide_rsp_t  exp;
    idx = rq.add[6:3];
    if (rq.wen) begin
      exp.r_data = model_mem[idx];
    end else begin
      for (int b = 0; b < WBW; b++) begin
        if (rq.be[b]) begin
          model_mem[idx][8*b +: 8] = rq.data[8*b +: 8];
        end
      end
      exp.r_data = {NB_CHAN{DUMMY_WORD}};
    end
    acc_q.push_back(rq);
    exp_rsp_q.push_back(exp);
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int c = 0; c < NB_CHAN; c++) begin
        if (chan_req_o[c] && chan_gnt_i[c]) begin
          if (nreq_cnt[c] < acc_q.size()) begin
            check_narrow_req($sformatf("chan_req_o_data[%0d]", c), chan_req_o_data[c],
                             expected_slice(acc_q[nreq_cnt[c]], c));
            nreq_cnt[c]++;
          end else if (nreq_cnt[c] == acc_q.size() && req_i) begin
            // a slice of the request still waiting for gnt_o may reach memory first
            check_narrow_req($sformatf("chan_req_o_data[%0d]", c), chan_req_o_data[c],
                             expected_slice(wide_req_i, c));
            nreq_cnt[c]++;
          end else begin
            fail_with($sformatf("channel %0d issued a request no wide request accounts for",
                                c));
          end
        end
      end
      if (r_valid_o && rsp_cnt >= exp_rsp_q.size()) begin
        fail_with("r_valid_o went high with no wide request waiting for an answer");
      end else if (r_valid_o && r_ready_i) begin
        check_wide_rsp("wide_rsp_o", wide_rsp_o, exp_rsp_q[rsp_cnt]);
        rsp_cnt++;
      end
      if (req_i && gnt_o) begin
        accept_request(wide_req_i);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_with($sformatf("the run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  function automatic logic pick_ready();
    if (heavy_stall) begin
      return ({$random(seed)} % 4) == 0;
    end
    return ({$random(seed)} % 4) != 0;
  endfunction

  function automatic wide_req_t random_request();
    wide_req_t   rq;
    logic [31:0] lo;
    logic [31:0] hi;
    lo      = $random(seed);
    hi      = $random(seed);
    rq.add  = AW'(({$random(seed)} % N_WORDS) * WBW); // 8 byte aligned in the window
    rq.wen  = 1'($random(seed));
    rq.be   = WBW'($random(seed));
    rq.data = {hi, lo};
    return rq;
  endfunction

  // called just after a falling edge, returns just after the next one
  task automatic next_cycle();
    @(negedge clk_i);
    r_ready_i = pick_ready();
  endtask

  task automatic send_request(input wide_req_t rq);
    logic taken;
    req_i      = 1'b1;
    wide_req_i = rq; // held steady until granted
    taken      = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken = gnt_o;
      next_cycle();
    end
    req_i = 1'b0;
  endtask

  task automatic run_traffic(input int unsigned n);
    int unsigned gap;
    for (int unsigned i = 0; i < n; i++) begin
      send_request(random_request());
      gap = {$random(seed)} % 4;
      repeat (gap) next_cycle();
    end
  endtask

  task automatic wait_idle();
    while (rsp_cnt != exp_rsp_q.size()) begin
      next_cycle();
    end
  endtask

  initial begin
    wide_req_t pre;
    int        bad_chan;
    seed        = SEED;
    heavy_stall = 1'b0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    req_i       = 1'b0;
    r_ready_i   = 1'b0;
    wide_req_i  = '0;
    rsp_cnt     = 0;
    cycle_cnt   = 0;
    for (int c = 0; c < NB_CHAN; c++) begin
      nreq_cnt[c] = 0;
    end
    for (int w = 0; w < N_WORDS; w++) begin
      model_mem[w] = '0;
    end
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // full writes give every word in the window a known value
    for (int w = 0; w < N_WORDS; w++) begin
      pre      = random_request();
      pre.add  = AW'(w * WBW);
      pre.wen  = 1'b0;
      pre.be   = '1;
      send_request(pre);
    end
    run_traffic(N_RANDOM);
    wait_idle();

    clear_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
    if (gnt_o || r_valid_o) begin
      fail_with("gnt_o or r_valid_o was high in the first cycle after clear_i");
    end
    for (int c = 0; c < NB_CHAN; c++) begin
      if (chan_req_o[c] || chan_r_ready_o[c]) begin
        fail_with($sformatf("channel %0d request or response ready was high after clear_i",
                            c));
      end
    end

    heavy_stall = 1'b1; // response FIFOs fill and push back on the channels
    run_traffic(N_RANDOM);
    heavy_stall = 1'b0;
    wait_idle();

    bad_chan = -1;
    for (int c = 0; c < NB_CHAN; c++) begin
      if (nreq_cnt[c] != acc_q.size()) begin
        bad_chan = c;
      end
    end
    if (bad_chan < 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_with($sformatf("channel %0d saw %0d requests for %0d wide requests",
                          bad_chan, nreq_cnt[bad_chan], acc_q.size()));
    end
  end

endmodule

`default_nettype wire

/* verification/tb_mem_channels.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_split_config.svh"

// behavioral word memory behind every channel, with random grant and response stalls
module tb_mem_channels #(
  parameter int unsigned                NB_CHAN    = `TCDM_NB_CHAN,
  parameter int                         SEED       = 1,
  parameter logic [`TCDM_NARROW_DW-1:0] DUMMY_WORD = '0
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i      [NB_CHAN],
  input  wire tcdm_bus_pkg::narrow_req_t req_data_i [NB_CHAN],
  input  wire logic                      r_ready_i  [NB_CHAN],
  output logic                           gnt_o      [NB_CHAN],
  output logic                           r_valid_o  [NB_CHAN],
  output tcdm_bus_pkg::narrow_rsp_t      rsp_o      [NB_CHAN]
);

  import tcdm_bus_pkg::*;

  localparam int unsigned WORDS = 32; // 128 byte test window, word index is add[6:2]
  localparam int unsigned SLOTS = 4;  // answers a channel holds before it stops granting
  localparam int unsigned NBW   = `TCDM_NARROW_DW / 8;

  logic [`TCDM_NARROW_DW-1:0] mem [NB_CHAN][WORDS];
  narrow_rsp_t q_rsp    [NB_CHAN][SLOTS]; // pending answers in issue order
  int          q_due    [NB_CHAN][SLOTS]; // first cycle in which each answer may be shown
  int unsigned rd_ptr   [NB_CHAN];
  int unsigned wr_ptr   [NB_CHAN];
  int unsigned pending  [NB_CHAN];
  int          last_due [NB_CHAN];        // keeps answers in order despite random delays
  int          cyc;
  int          seed;

  initial begin
    seed = SEED;
    cyc  = 0;
    for (int c = 0; c < NB_CHAN; c++) begin
      rd_ptr[c]    = 0;
      wr_ptr[c]    = 0;
      pending[c]   = 0;
      last_due[c]  = 0;
      gnt_o[c]     = 1'b0;
      r_valid_o[c] = 1'b0;
      rsp_o[c]     = '0;
      for (int w = 0; w < WORDS; w++) begin
        mem[c][w] = {8'hA5, 8'(c), 16'(w)}; // fill tells channel and word apart
      end
    end
  end

  // memory state moves on the rising edge, outputs change only on the falling edge
  always @(posedge clk_i) begin : serve
    logic [4:0]  idx;
    narrow_rsp_t ans;
    int          due;
    cyc = cyc + 1;
    for (int c = 0; c < NB_CHAN; c++) begin
      if (r_valid_o[c] && r_ready_i[c]) begin
        rd_ptr[c]  = (rd_ptr[c] + 1) % SLOTS;
        pending[c] = pending[c] - 1;
      end
      if (req_i[c] && gnt_o[c]) begin
        idx = req_data_i[c].add[6:2];
        if (req_data_i[c].wen) begin
          ans.r_data = mem[c][idx];
        end else begin
          for (int b = 0; b < NBW; b++) begin
            if (req_data_i[c].be[b]) begin
              mem[c][idx][8*b +: 8] = req_data_i[c].data[8*b +: 8];
            end
          end
          ans.r_data = DUMMY_WORD; // writes still answer once
        end
        due = cyc + 1 + int'({$random(seed)} % 3); // one to three cycles after the grant
        if (due < last_due[c]) begin
          due = last_due[c];
        end
        last_due[c]             = due;
        q_rsp[c][wr_ptr[c]]     = ans;
        q_due[c][wr_ptr[c]]     = due;
        wr_ptr[c]               = (wr_ptr[c] + 1) % SLOTS;
        pending[c]              = pending[c] + 1;
      end
    end
  end

  always @(negedge clk_i) begin
    for (int c = 0; c < NB_CHAN; c++) begin
      gnt_o[c]     = rst_ni && (pending[c] < SLOTS) && (({$random(seed)} % 4) != 0);
      r_valid_o[c] = (pending[c] != 0) && (q_due[c][rd_ptr[c]] <= cyc);
      rsp_o[c]     = r_valid_o[c] ? q_rsp[c][rd_ptr[c]] : '0; // held until r_ready
    end
  end

endmodule

`default_nettype wire

/* rtl/tcdm_split_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_split_config.svh"

// splitter with one array entry per memory channel on its ports
module tcdm_split_top #(
  parameter int unsigned NB_CHAN    = `TCDM_NB_CHAN,
  parameter int unsigned FIFO_DEPTH = `TCDM_FIFO_DEPTH
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      clear_i,
  input  wire logic                      req_i,
  input  wire tcdm_bus_pkg::wide_req_t   wide_req_i,
  output logic                           gnt_o,
  output logic                           r_valid_o,
  output tcdm_bus_pkg::wide_rsp_t        wide_rsp_o,
  input  wire logic                      r_ready_i,
  output logic                           chan_req_o      [NB_CHAN],
  output tcdm_bus_pkg::narrow_req_t      chan_req_o_data [NB_CHAN],
  input  wire logic                      chan_gnt_i      [NB_CHAN],
  input  wire logic                      chan_r_valid_i  [NB_CHAN],
  input  wire tcdm_bus_pkg::narrow_rsp_t chan_rsp_i      [NB_CHAN],
  output logic                           chan_r_ready_o  [NB_CHAN]
);

  import tcdm_bus_pkg::*;

  logic [NB_CHAN-1:0]        req_vec;
  narrow_req_t [NB_CHAN-1:0] req_data_vec;
  logic [NB_CHAN-1:0]        gnt_vec;
  logic [NB_CHAN-1:0]        r_valid_vec;
  narrow_rsp_t [NB_CHAN-1:0] rsp_vec;
  logic [NB_CHAN-1:0]        r_ready_vec;

  // unpacked channel ports to and from the packed splitter vectors
  always_comb begin
    for (int c = 0; c < NB_CHAN; c++) begin
      chan_req_o[c]      = req_vec[c];
      chan_req_o_data[c] = req_data_vec[c];
      chan_r_ready_o[c]  = r_ready_vec[c];
      gnt_vec[c]         = chan_gnt_i[c];
      r_valid_vec[c]     = chan_r_valid_i[c];
      rsp_vec[c]         = chan_rsp_i[c];
    end
  end

  tcdm_split #(
    .NB_CHAN    ( NB_CHAN    ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_split (
    .clk_i           ( clk_i        ),
    .rst_ni          ( rst_ni       ),
    .clear_i         ( clear_i      ),
    .req_i           ( req_i        ),
    .wide_req_i      ( wide_req_i   ),
    .gnt_o           ( gnt_o        ),
    .r_valid_o       ( r_valid_o    ),
    .wide_rsp_o      ( wide_rsp_o   ),
    .r_ready_i       ( r_ready_i    ),
    .chan_req_o      ( req_vec      ),
    .chan_req_data_o ( req_data_vec ),
    .chan_gnt_i      ( gnt_vec      ),
    .chan_r_valid_i  ( r_valid_vec  ),
    .chan_rsp_i      ( rsp_vec      ),
    .chan_r_ready_o  ( r_ready_vec  )
  );

endmodule

`default_nettype wire

/* rtl/tcdm_split.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_split_config.svh"

// splits wide accesses into one word per channel and merges the answers back
module tcdm_split #(
  parameter int unsigned NB_CHAN    = `TCDM_NB_CHAN,
  parameter int unsigned FIFO_DEPTH = `TCDM_FIFO_DEPTH
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    clear_i,
  input  wire logic                                    req_i,
  input  wire tcdm_bus_pkg::wide_req_t                 wide_req_i,
  output logic                                         gnt_o,
  output logic                                         r_valid_o,
  output tcdm_bus_pkg::wide_rsp_t                      wide_rsp_o,
  input  wire logic                                    r_ready_i,
  output logic [NB_CHAN-1:0]                           chan_req_o,
  output tcdm_bus_pkg::narrow_req_t [NB_CHAN-1:0]      chan_req_data_o,
  input  wire logic [NB_CHAN-1:0]                      chan_gnt_i,
  input  wire logic [NB_CHAN-1:0]                      chan_r_valid_i,
  input  wire tcdm_bus_pkg::narrow_rsp_t [NB_CHAN-1:0] chan_rsp_i,
  output logic [NB_CHAN-1:0]                           chan_r_ready_o
);

  import tcdm_bus_pkg::*;
  import split_state_pkg::*;

  localparam int unsigned AW  = `TCDM_AW;
  localparam int unsigned NDW = `TCDM_NARROW_DW;
  localparam int unsigned NBW = NDW / 8; // bytes per channel word

  narrow_req_t [NB_CHAN-1:0] slice_req;
  narrow_rsp_t [NB_CHAN-1:0] rsp_head;
  logic [NB_CHAN-1:0]        buf_want;   // slices still to be queued this cycle
  logic [NB_CHAN-1:0]        buf_push;
  logic [NB_CHAN-1:0]        buf_gnt;
  logic [NB_CHAN-1:0]        gnt_held;   // slices queued in earlier cycles
  logic [NB_CHAN-1:0]        gnt_mask_d;
  logic [NB_CHAN-1:0]        gnt_mask_q;
  logic [NB_CHAN-1:0]        rsp_valid;
  logic [NB_CHAN-1:0]        rsp_held;   // heads that arrived while waiting
  logic [NB_CHAN-1:0]        rsp_mask_d;
  logic [NB_CHAN-1:0]        rsp_mask_q;
  logic                      rsp_pop;
  gnt_state_t                cs_gnt;
  gnt_state_t                ns_gnt;
  rvalid_state_t             cs_rvalid;
  rvalid_state_t             ns_rvalid;

  // channel c gets the word at add + c*NBW and slice c of be and data
  always_comb begin
    for (int c = 0; c < NB_CHAN; c++) begin
      slice_req[c].add  = wide_req_i.add + AW'(c * NBW);
      slice_req[c].wen  = wide_req_i.wen;
      slice_req[c].be   = wide_req_i.be[c*NBW +: NBW];
      slice_req[c].data = wide_req_i.data[c*NDW +: NDW];
    end
  end

  // a slice that already sits in its FIFO is not queued a second time
  assign gnt_held = (cs_gnt == NO_GNT) ? gnt_mask_q : '0;
  assign buf_want = {NB_CHAN{req_i}} & ~gnt_held;
  assign buf_push = buf_want & buf_gnt;

  // wide grant only once every slice is either queued now or queued before
  assign gnt_o = req_i & (&(buf_gnt | gnt_held));

  assign gnt_mask_d = gnt_held | buf_push; // restarts from this cycle's pushes in GNT

  always_comb begin
    ns_gnt = cs_gnt;
    if (cs_gnt == GNT) begin
      if (req_i && !(&buf_gnt)) begin
        ns_gnt = NO_GNT; // partial grant, remember what went through
      end
    end else if (gnt_o) begin
      ns_gnt = GNT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_gnt     <= GNT;
      gnt_mask_q <= '0;
    end else if (clear_i) begin
      cs_gnt     <= GNT;
      gnt_mask_q <= '0;
    end else begin
      cs_gnt     <= ns_gnt;
      gnt_mask_q <= gnt_mask_d;
    end
  end

  // response heads stay put in their FIFOs until the whole word is there
  assign rsp_held   = (cs_rvalid == NO_RVALID) ? rsp_mask_q : '0;
  assign r_valid_o  = &(rsp_valid | rsp_held);
  assign rsp_pop    = r_valid_o & r_ready_i; // all channels pop together
  assign rsp_mask_d = rsp_held | rsp_valid;

  always_comb begin
    ns_rvalid = cs_rvalid;
    if (cs_rvalid == RVALID) begin
      if ((|rsp_valid) && !(&rsp_valid)) begin
        ns_rvalid = NO_RVALID; // some channels answered, the rest are late
      end
    end else if (r_valid_o) begin
      ns_rvalid = RVALID;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_rvalid  <= RVALID;
      rsp_mask_q <= '0;
    end else if (clear_i) begin
      cs_rvalid  <= RVALID;
      rsp_mask_q <= '0;
    end else begin
      cs_rvalid  <= ns_rvalid;
      rsp_mask_q <= rsp_mask_d;
    end
  end

  // channel 0 lands in the low bits, mirroring the request slicing
  always_comb begin
    for (int c = 0; c < NB_CHAN; c++) begin
      wide_rsp_o.r_data[c*NDW +: NDW] = rsp_head[c].r_data;
    end
  end

  for (genvar c = 0; c < NB_CHAN; c++) begin : gen_chan
    tcdm_chan_buffer #(
      .DEPTH ( FIFO_DEPTH )
    ) i_buffer (
      .clk_i          ( clk_i              ),
      .rst_ni         ( rst_ni             ),
      .clear_i        ( clear_i            ),
      .push_i         ( buf_push[c]        ),
      .req_data_i     ( slice_req[c]       ),
      .gnt_o          ( buf_gnt[c]         ),
      .rsp_pop_i      ( rsp_pop            ),
      .rsp_valid_o    ( rsp_valid[c]       ),
      .rsp_data_o     ( rsp_head[c]        ),
      .mem_req_o      ( chan_req_o[c]      ),
      .mem_req_data_o ( chan_req_data_o[c] ),
      .mem_gnt_i      ( chan_gnt_i[c]      ),
      .mem_r_valid_i  ( chan_r_valid_i[c]  ),
      .mem_rsp_i      ( chan_rsp_i[c]      ),
      .mem_r_ready_o  ( chan_r_ready_o[c]  )
    );
  end

endmodule

`default_nettype wire

/* rtl/tcdm_chan_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_split_config.svh"

// decouples one memory channel from the splitter with a request and a response FIFO
module tcdm_chan_buffer #(
  parameter int unsigned DEPTH = `TCDM_FIFO_DEPTH
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      clear_i,
  input  wire logic                      push_i,         // splitter queues a slice
  input  wire tcdm_bus_pkg::narrow_req_t req_data_i,
  output logic                           gnt_o,          // room in the request FIFO
  input  wire logic                      rsp_pop_i,
  output logic                           rsp_valid_o,
  output tcdm_bus_pkg::narrow_rsp_t      rsp_data_o,
  output logic                           mem_req_o,
  output tcdm_bus_pkg::narrow_req_t      mem_req_data_o,
  input  wire logic                      mem_gnt_i,
  input  wire logic                      mem_r_valid_i,
  input  wire tcdm_bus_pkg::narrow_rsp_t mem_rsp_i,
  output logic                           mem_r_ready_o
);

  import tcdm_bus_pkg::*;

  logic req_full;
  logic rsp_full;
  logic rsp_push;
  logic active_q; // low in the cycle after reset or clear

  // the memory sees the request FIFO head and takes it on its grant
  tcdm_fifo #(
    .payload_t ( narrow_req_t ),
    .DEPTH     ( DEPTH        )
  ) i_req_fifo (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .clear_i ( clear_i        ),
    .push_i  ( push_i         ),
    .data_i  ( req_data_i     ),
    .full_o  ( req_full       ),
    .pop_i   ( mem_gnt_i      ),
    .valid_o ( mem_req_o      ),
    .data_o  ( mem_req_data_o )
  );

  assign gnt_o = ~req_full;

  // responses are accepted only while there is room, otherwise the memory holds them
  assign mem_r_ready_o = active_q & ~rsp_full;
  assign rsp_push      = mem_r_valid_i & mem_r_ready_o;

  tcdm_fifo #(
    .payload_t ( narrow_rsp_t ),
    .DEPTH     ( DEPTH        )
  ) i_rsp_fifo (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .clear_i ( clear_i     ),
    .push_i  ( rsp_push    ),
    .data_i  ( mem_rsp_i   ),
    .full_o  ( rsp_full    ),
    .pop_i   ( rsp_pop_i   ),
    .valid_o ( rsp_valid_o ),
    .data_o  ( rsp_data_o  )
  );

  // the channel starts taking memory responses one cycle after reset or clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else begin
      active_q <= ~clear_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/tcdm_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// circular buffer FIFO, the payload type is set per instance
module tcdm_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     clear_i,
  input  wire logic     push_i,  // write strobe
  input  wire payload_t data_i,
  output logic          full_o,
  input  wire logic     pop_i,   // read strobe, ignored while empty
  output logic          valid_o, // head holds an item
  output payload_t      data_o
);

  localparam int unsigned PW = $clog2(DEPTH);

  payload_t      mem_q [DEPTH]; // storage, no reset needed
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0]   count_q;      // one extra bit so that DEPTH fits
  logic          do_push;
  logic          do_pop;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    ptr_next = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == (PW + 1)'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q]; // head is visible the cycle after its push

  assign do_pop  = pop_i & valid_o;
  assign do_push = push_i & (~full_o | do_pop); // a full FIFO takes a push if it pops too

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // drop everything queued
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither keep the level
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/split_state_pkg.sv */
`default_nettype none

// states of the two lockstep machines in the splitter
package split_state_pkg;

  // NO_GNT means some slices of the pending request are already queued
  typedef enum logic {
    GNT,
    NO_GNT
  } gnt_state_t;

  // NO_RVALID means some response heads arrived and the rest are awaited
  typedef enum logic {
    RVALID,
    NO_RVALID
  } rvalid_state_t;

endpackage

`default_nettype wire

/* rtl/tcdm_bus_pkg.sv */
`default_nettype none

`include "tcdm_split_config.svh"

// request and response payloads on the wide port and on the channels
package tcdm_bus_pkg;

  // wide request as issued by the accelerator
  typedef struct packed {
    logic [`TCDM_AW-1:0]        add;  // byte address of the first channel word
    logic                       wen;  // high for a read, low for a write
    logic [`TCDM_WIDE_DW/8-1:0] be;   // one enable per byte of data
    logic [`TCDM_WIDE_DW-1:0]   data; // write data, ignored on reads
  } wide_req_t;

  // merged wide response
  typedef struct packed {
    logic [`TCDM_WIDE_DW-1:0] r_data; // channel 0 sits in the low bits
  } wide_rsp_t;

  // one channel slice of a wide request
  typedef struct packed {
    logic [`TCDM_AW-1:0]          add;  // wide address plus the channel byte offset
    logic                         wen;
    logic [`TCDM_NARROW_DW/8-1:0] be;
    logic [`TCDM_NARROW_DW-1:0]   data;
  } narrow_req_t;

  // one channel response word
  typedef struct packed {
    logic [`TCDM_NARROW_DW-1:0] r_data; // dummy word on writes
  } narrow_rsp_t;

endpackage

`default_nettype wire

/* rtl/tcdm_split_config.svh */
`ifndef TCDM_SPLIT_CONFIG_SVH
`define TCDM_SPLIT_CONFIG_SVH

// width of the accelerator side data word in bits
`define TCDM_WIDE_DW 64

// number of memory channels the wide word is split across
`define TCDM_NB_CHAN 2

// entries in each request and response FIFO, at least 2
`define TCDM_FIFO_DEPTH 4

// byte address width on both sides
`define TCDM_AW 32

// each channel carries one equal slice of the wide word
`define TCDM_NARROW_DW (`TCDM_WIDE_DW / `TCDM_NB_CHAN)

`endif
